/* src.f */
source/apb_sub_pkg.sv
source/ahb_apb_bridge.sv
source/gpio_block.sv
source/interval_timer.sv
source/power_wake_ctrl.sv
source/apb_subsystem.sv
bench/apb_checker.sv
bench/tb_apb_subsystem.sv

/* Makefile */
# Verilator build and run of the APB subsystem testbench

TOP = tb_apb_subsystem

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, and check for the pass message"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing -f src.f --top-module $(TOP) -Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Simulation PASSED"

clean:
	rm -rf obj_dir

/* bench/tb_apb_subsystem.sv */
// Testbench top with clock, reset, test table, AHB transfer task and pin stimulus
`timescale 1ns/1ps
`default_nettype none

module tb_apb_subsystem;

  localparam int GW = 16;
  localparam int LIMIT = 200;                            // Cycles per wait
  localparam logic [31:0] G_B = apb_sub_pkg::APB_BASE;
  localparam logic [31:0] T_B = apb_sub_pkg::APB_BASE + 32'h0001_0000;
  localparam logic [31:0] P_B = apb_sub_pkg::APB_BASE + 32'h0002_0000;
  // Table operations
  localparam int OP_WR = 0, OP_RD = 1, OP_RDLE = 2, OP_RDERR = 3;
  localparam int OP_PINS = 4, OP_CHK = 5, OP_WAIT = 6, OP_WRERR = 7;
  // Observed signal selects
  localparam int S_PIN = 2, S_NOE = 3, S_GIRQ = 4, S_TIRQ = 5, S_PIRQ = 6, S_ISO = 7, S_RDY = 8;

  logic          clk = 1'b0;
  logic          rst_n;
  logic          hsel, hwrite, hready_in;
  logic [31:0]   haddr, hwdata;
  logic [1:0]    htrans;
  logic [GW-1:0] pins;
  logic [3:0]    ext_irq;
  wire  [31:0]   hrdata;
  wire           hready, gpio_irq, ttc_irq, pcm_irq, isolate_mem;
  wire  [1:0]    hresp;
  wire  [GW-1:0] pin_out, n_oe;

  string       names[$];
  int          ops[$];
  logic [31:0] addrs[$], datas[$], exps[$], masks[$];
  logic [31:0] rng = 32'd62242;
  logic [31:0] r_dout, r_oe, p1, p3;
  logic        timed_out = 1'b0;

  always #50 clk = ~clk;

  apb_subsystem #(.GPIO_WIDTH(GW), .NUM_EXT_IRQS(4)) uut (
    .i_hclk(clk), .i_rst_n(rst_n), .i_hsel(hsel), .i_haddr(haddr), .i_htrans(htrans),
    .i_hwrite(hwrite), .i_hwdata(hwdata), .i_hready_in(hready_in), .o_hrdata(hrdata),
    .o_hready(hready), .o_hresp(hresp), .i_gpio_pin_in(pins), .i_ext_irq(ext_irq),
    .o_gpio_pin_out(pin_out), .o_n_gpio_pin_oe(n_oe), .o_gpio_irq(gpio_irq),
    .o_ttc_irq(ttc_irq), .o_pcm_irq(pcm_irq), .o_isolate_mem(isolate_mem)
  );

  apb_checker #(.GPIO_WIDTH(GW)) chk (
    .i_hrdata(hrdata), .i_hready(hready), .i_hresp(hresp), .i_pin_out(pin_out),
    .i_n_oe(n_oe), .i_gpio_irq(gpio_irq), .i_ttc_irq(ttc_irq), .i_pcm_irq(pcm_irq),
    .i_isolate_mem(isolate_mem)
  );

  function automatic logic [31:0] xorshift();
    rng = rng ^ (rng << 13);
    rng = rng ^ (rng >> 17);
    rng = rng ^ (rng << 5);
    return rng;
  endfunction

  function automatic void add_row(input string n, input int op, input logic [31:0] a,
                                  input logic [31:0] d, input logic [31:0] e,
                                  input logic [31:0] m);
    names.push_back(n);
    ops.push_back(op);
    addrs.push_back(a);
    datas.push_back(d);
    exps.push_back(e);
    masks.push_back(m);
  endfunction

  // One AHB transfer, address phase then data phase until hready returns
  task automatic ahb_xfer(input logic [31:0] addr, input logic wr, input logic [31:0] data,
                          output logic ok);
    int n;
    @(negedge clk);
    hsel   = 1'b1;
    haddr  = addr;
    htrans = apb_sub_pkg::HTRANS_NONSEQ;
    hwrite = wr;
    @(negedge clk);
    hsel   = 1'b0;
    htrans = 2'b00;                                      // IDLE
    hwdata = data;
    n = 0;
    while (!hready && n < LIMIT) begin
      @(negedge clk);
      n++;
    end
    ok = hready;
  endtask

  task automatic drive_pins(input logic [31:0] d);
    @(negedge clk);
    pins    = d[GW-1:0];
    ext_irq = d[19:16];
    if (d[19:16] != 4'd0) begin
      @(negedge clk);
      ext_irq = 4'd0;                                    // One-cycle pulse
    end
    repeat (4) @(negedge clk);                           // Covers sync and status delay
  endtask

  // ----------------------------------------
  // Test table
  // ----------------------------------------
  task automatic build_table();
    r_dout = xorshift() & 32'hFFFF;
    r_oe   = xorshift() & 32'hFFFF;
    p1     = xorshift() & 32'hFFFF;
    p3     = p1 ^ 32'h8001;
    add_row("rst_hready", OP_CHK, S_RDY, 0, 1, 1);
    add_row("rst_n_oe", OP_CHK, S_NOE, 0, 32'hFFFF, 32'hFFFF);
    add_row("rst_gpio_irq", OP_CHK, S_GIRQ, 0, 0, 1);
    add_row("rst_ttc_irq", OP_CHK, S_TIRQ, 0, 0, 1);
    add_row("rst_pcm_irq", OP_CHK, S_PIRQ, 0, 0, 1);
    add_row("rst_gpio_dout", OP_RD, G_B, 0, 0, '1);
    add_row("rst_ttc_ctrl", OP_RD, T_B, 0, 0, '1);
    add_row("rst_pwr_ctrl", OP_RD, P_B, 0, 0, '1);
    add_row("wr_dout", OP_WR, G_B + 32'h00, r_dout, 0, 0);
    add_row("wr_oe", OP_WR, G_B + 32'h04, r_oe, 0, 0);
    add_row("pin_out", OP_CHK, S_PIN, 0, r_dout, 32'hFFFF);
    add_row("n_oe", OP_CHK, S_NOE, 0, ~r_oe, 32'hFFFF);
    add_row("rd_dout", OP_RD, G_B + 32'h00, 0, r_dout, '1);
    add_row("rd_oe", OP_RD, G_B + 32'h04, 0, r_oe, '1);
    add_row("pins_p1", OP_PINS, 0, p1, 0, 0);
    add_row("rd_din", OP_RD, G_B + 32'h08, 0, p1, '1);
    add_row("clr_stat", OP_WR, G_B + 32'h10, 32'hFFFF, 0, 0);
    add_row("wr_mask", OP_WR, G_B + 32'h0C, 32'h0001, 0, 0);
    add_row("pins_masked", OP_PINS, 0, p1 ^ 32'h8000, 0, 0);
    add_row("masked_irq_low", OP_CHK, S_GIRQ, 0, 0, 1);
    add_row("clr_stat2", OP_WR, G_B + 32'h10, 32'hFFFF, 0, 0);
    add_row("pins_unmasked", OP_PINS, 0, p3, 0, 0);
    add_row("gpio_irq_high", OP_WAIT, S_GIRQ, 0, 1, 1);
    add_row("rd_stat_xor", OP_RD, G_B + 32'h10, 0, 32'h0001, '1);
    add_row("clr_stat3", OP_WR, G_B + 32'h10, 32'hFFFF, 0, 0);
    add_row("gpio_irq_clr", OP_CHK, S_GIRQ, 0, 0, 1);
    // Timer, period interval+1
    add_row("wr_interval", OP_WR, T_B + 32'h04, 9, 0, 0);
    add_row("ttc_enable", OP_WR, T_B + 32'h00, 3, 0, 0);
    add_row("ttc_irq_high", OP_WAIT, S_TIRQ, 0, 1, 1);
    add_row("rd_count_le9", OP_RDLE, T_B + 32'h08, 0, 9, 0);
    add_row("ttc_stop", OP_WR, T_B + 32'h00, 2, 0, 0);
    add_row("ttc_stat_clr", OP_WR, T_B + 32'h0C, 1, 0, 0);
    add_row("ttc_irq_low", OP_CHK, S_TIRQ, 0, 0, 1);
    add_row("wr_interval2", OP_WR, T_B + 32'h04, 5, 0, 0);
    add_row("ttc_disable", OP_WR, T_B + 32'h00, 0, 0, 0);
    add_row("ttc_reenable", OP_WR, T_B + 32'h00, 3, 0, 0);
    add_row("ttc_irq_again", OP_WAIT, S_TIRQ, 0, 1, 1);
    add_row("ttc_off", OP_WR, T_B + 32'h00, 0, 0, 0);
    add_row("ttc_stat_clr2", OP_WR, T_B + 32'h0C, 1, 0, 0);
    // Wake rule
    add_row("pwr_stat_clr", OP_WR, P_B + 32'h04, 1, 0, 0);
    add_row("pcm_irq_low", OP_CHK, S_PIRQ, 0, 0, 1);
    add_row("ext_pulse", OP_PINS, 0, p3 | 32'h1_0000, 0, 0);
    add_row("pcm_wake_ext", OP_WAIT, S_PIRQ, 0, 1, 1);
    add_row("pwr_stat_clr2", OP_WR, P_B + 32'h04, 1, 0, 0);
    add_row("pcm_cleared", OP_CHK, S_PIRQ, 0, 0, 1);
    add_row("set_isolate", OP_WR, P_B + 32'h00, 1, 0, 0);
    add_row("isolate_high", OP_CHK, S_ISO, 0, 1, 1);
    add_row("ext_pulse_iso", OP_PINS, 0, p3 | 32'h1_0000, 0, 0);
    add_row("pcm_no_wake", OP_CHK, S_PIRQ, 0, 0, 1);
    add_row("pins_iso_toggle", OP_PINS, 0, p3 ^ 32'h0001, 0, 0);
    add_row("pcm_wake_gpio", OP_WAIT, S_PIRQ, 0, 1, 1);
    // Unmapped accesses, the write would alias GPIO_DOUT if the window were ignored
    add_row("err_slot3", OP_RDERR, G_B + 32'h0003_0000, 0, 0, 0);
    add_row("err_outside", OP_RDERR, 32'h0100_0000, 0, 0, 0);
    add_row("err_wr_outside", OP_WRERR, 32'h0180_0000, ~r_dout & 32'hFFFF, 0, 0);
    add_row("rd_dout_kept", OP_RD, G_B + 32'h00, 0, r_dout, '1);
  endtask

  initial begin
    int n;
    logic ok;
    rst_n = 1'b0;
    hsel = 1'b0;
    hwrite = 1'b0;
    hready_in = 1'b1;
    haddr = '0;
    hwdata = '0;
    htrans = 2'b00;
    pins = '0;
    ext_irq = '0;
    build_table();
    repeat (10) @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);
    for (int i = 0; i < names.size(); i++) begin
      ok = 1'b1;
      case (ops[i])
        OP_PINS: drive_pins(datas[i]);
        OP_CHK: begin
          repeat (4) @(negedge clk);
          chk.check_eq(names[i], addrs[i], exps[i], masks[i]);
        end
        OP_WAIT: begin
          n = 0;
          while ((chk.observe(addrs[i]) & masks[i]) !== (exps[i] & masks[i]) && n < LIMIT) begin
            @(negedge clk);
            n++;
          end
          if (n >= LIMIT) ok = 1'b0;
          else chk.check_eq(names[i], addrs[i], exps[i], masks[i]);
        end
        default: begin
          ahb_xfer(addrs[i], ops[i] == OP_WR || ops[i] == OP_WRERR, datas[i], ok);
          if (ok && ops[i] == OP_RDLE) chk.check_le(names[i], exps[i]);
          else if (ok && (ops[i] == OP_RDERR || ops[i] == OP_WRERR))
            chk.check_xfer(names[i], 0, 0, apb_sub_pkg::HRESP_ERROR);
          else if (ok) chk.check_xfer(names[i], exps[i], masks[i], apb_sub_pkg::HRESP_OKAY);
        end
      endcase
      if (!ok) begin
        $display("Timeout in %s: no response within %0d cycles", names[i], LIMIT);
        timed_out = 1'b1;
        break;
      end
    end
    chk.print_counts();
    if (timed_out || chk.fail_cnt != 0) begin
      $display("Simulation FAILED");
    end else begin
      $display("Simulation PASSED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* bench/apb_checker.sv */
// Checker that samples bus responses, pins and interrupts, compares them and keeps counts
`timescale 1ns/1ps
`default_nettype none

module apb_checker #(
  parameter int GPIO_WIDTH = 16
) (
  input wire [31:0]           i_hrdata,
  input wire                  i_hready,
  input wire [1:0]            i_hresp,
  input wire [GPIO_WIDTH-1:0] i_pin_out,
  input wire [GPIO_WIDTH-1:0] i_n_oe,
  input wire                  i_gpio_irq,
  input wire                  i_ttc_irq,
  input wire                  i_pcm_irq,
  input wire                  i_isolate_mem
);

  int pass_cnt = 0;
  int fail_cnt = 0;

  // Signal select codes shared with the bench table
  function automatic logic [31:0] observe(input int sel);
    case (sel)
      2:       observe = 32'(i_pin_out);
      3:       observe = 32'(i_n_oe);
      4:       observe = {31'b0, i_gpio_irq};
      5:       observe = {31'b0, i_ttc_irq};
      6:       observe = {31'b0, i_pcm_irq};
      7:       observe = {31'b0, i_isolate_mem};
      8:       observe = {31'b0, i_hready};
      default: observe = i_hrdata;
    endcase
  endfunction

  // ----------------------------------------
  // Comparisons, one line per test
  // ----------------------------------------
  task automatic check_xfer(input string name, input logic [31:0] exp,
                            input logic [31:0] mask, input logic [1:0] exp_resp);
    if (i_hresp !== exp_resp) begin
      fail_cnt++;
      $display("FAIL %s: expected hresp %0h, actual %0h", name, exp_resp, i_hresp);
    end else if ((i_hrdata & mask) !== (exp & mask)) begin
      fail_cnt++;
      $display("FAIL %s: expected %08h, actual %08h", name, exp & mask, i_hrdata & mask);
    end else begin
      pass_cnt++;
      $display("PASS %s", name);
    end
  endtask

  task automatic check_le(input string name, input logic [31:0] limit);
    if (i_hresp === 2'b00 && i_hrdata <= limit) begin
      pass_cnt++;
      $display("PASS %s", name);
    end else begin
      fail_cnt++;
      $display("FAIL %s: expected <= %0d, actual %0d", name, limit, i_hrdata);
    end
  endtask

  task automatic check_eq(input string name, input int sel, input logic [31:0] exp,
                          input logic [31:0] mask);
    logic [31:0] act;
    act = observe(sel) & mask;
    if (act !== (exp & mask)) begin
      fail_cnt++;
      $display("FAIL %s: expected %08h, actual %08h", name, exp & mask, act);
    end else begin
      pass_cnt++;
      $display("PASS %s", name);
    end
  endtask

  task automatic print_counts();
    $display("Tests passed: %0d, failed: %0d", pass_cnt, fail_cnt);
  endtask

endmodule

`default_nettype wire

/* source/apb_subsystem.sv */
// Subsystem top level joining the AHB-to-APB bridge, GPIO, timer and power controller
`timescale 1ns/1ps
`default_nettype none

module apb_subsystem #(
  parameter int GPIO_WIDTH   = 16,
  parameter int NUM_EXT_IRQS = 4
) (
  input  wire                     i_hclk,
  input  wire                     i_rst_n,
  // AHB-lite slave port
  input  wire                     i_hsel,
  input  wire  [31:0]             i_haddr,
  input  wire  [1:0]              i_htrans,
  input  wire                     i_hwrite,
  input  wire  [31:0]             i_hwdata,
  input  wire                     i_hready_in,
  output logic [31:0]             o_hrdata,
  output logic                    o_hready,
  output logic [1:0]              o_hresp,
  // Pins and interrupts
  input  wire  [GPIO_WIDTH-1:0]   i_gpio_pin_in,
  input  wire  [NUM_EXT_IRQS-1:0] i_ext_irq,
  output logic [GPIO_WIDTH-1:0]   o_gpio_pin_out,
  output logic [GPIO_WIDTH-1:0]   o_n_gpio_pin_oe,
  output logic                    o_gpio_irq,
  output logic                    o_ttc_irq,
  output logic                    o_pcm_irq,
  output logic                    o_isolate_mem
);

  // ----------------------------------------
  // Shared APB bus
  // ----------------------------------------
  logic [4:0]  paddr;
  logic        pwrite;
  logic [31:0] pwdata;
  logic        penable;
  logic        psel_gpio, psel_ttc, psel_pwr;        // One select per peer
  logic [31:0] prdata_gpio, prdata_ttc, prdata_pwr;

  ahb_apb_bridge u_bridge (
    .i_hclk        (i_hclk),
    .i_rst_n       (i_rst_n),
    .i_hsel        (i_hsel),
    .i_haddr       (i_haddr),
    .i_htrans      (i_htrans),
    .i_hwrite      (i_hwrite),
    .i_hwdata      (i_hwdata),
    .i_hready_in   (i_hready_in),
    .o_hrdata      (o_hrdata),
    .o_hready      (o_hready),
    .o_hresp       (o_hresp),
    .i_prdata_gpio (prdata_gpio),
    .i_prdata_ttc  (prdata_ttc),
    .i_prdata_pwr  (prdata_pwr),
    .o_paddr       (paddr),
    .o_pwrite      (pwrite),
    .o_pwdata      (pwdata),
    .o_penable     (penable),
    .o_psel_gpio   (psel_gpio),
    .o_psel_ttc    (psel_ttc),
    .o_psel_pwr    (psel_pwr)
  );

  gpio_block #(.GPIO_WIDTH(GPIO_WIDTH)) u_gpio (
    .i_hclk          (i_hclk),
    .i_rst_n         (i_rst_n),
    .i_psel          (psel_gpio),
    .i_penable       (penable),
    .i_pwrite        (pwrite),
    .i_paddr         (paddr),
    .i_pwdata        (pwdata),
    .i_gpio_pin_in   (i_gpio_pin_in),
    .o_prdata        (prdata_gpio),
    .o_gpio_pin_out  (o_gpio_pin_out),
    .o_n_gpio_pin_oe (o_n_gpio_pin_oe),
    .o_gpio_irq      (o_gpio_irq)
  );

  interval_timer u_ttc (
    .i_hclk    (i_hclk),
    .i_rst_n   (i_rst_n),
    .i_psel    (psel_ttc),
    .i_penable (penable),
    .i_pwrite  (pwrite),
    .i_paddr   (paddr),
    .i_pwdata  (pwdata),
    .o_prdata  (prdata_ttc),
    .o_ttc_irq (o_ttc_irq)
  );

  // Wake detector sees both peer interrupts plus external lines
  power_wake_ctrl #(.NUM_EXT_IRQS(NUM_EXT_IRQS)) u_pwr (
    .i_hclk        (i_hclk),
    .i_rst_n       (i_rst_n),
    .i_psel        (psel_pwr),
    .i_penable     (penable),
    .i_pwrite      (pwrite),
    .i_paddr       (paddr),
    .i_pwdata      (pwdata),
    .i_gpio_irq    (o_gpio_irq),
    .i_ttc_irq     (o_ttc_irq),
    .i_ext_irq     (i_ext_irq),
    .o_prdata      (prdata_pwr),
    .o_isolate_mem (o_isolate_mem),
    .o_pcm_irq     (o_pcm_irq)
  );

endmodule

`default_nettype wire

/* source/power_wake_ctrl.sv */
// Memory isolate control register and wake-event detector for the power interrupt
`timescale 1ns/1ps
`default_nettype none

module power_wake_ctrl #(
  parameter int NUM_EXT_IRQS = 4
) (
  input  wire                     i_hclk,
  input  wire                     i_rst_n,
  input  wire                     i_psel,
  input  wire                     i_penable,
  input  wire                     i_pwrite,
  input  wire  [4:0]              i_paddr,
  input  wire  [31:0]             i_pwdata,
  input  wire                     i_gpio_irq,
  input  wire                     i_ttc_irq,
  input  wire  [NUM_EXT_IRQS-1:0] i_ext_irq,
  output logic [31:0]             o_prdata,
  output logic                    o_isolate_mem,
  output logic                    o_pcm_irq
);

  logic wr_en;
  logic wake_cond;   // Level wake request
  logic wake_cond_q; // Previous cycle, for edge detect
  logic pending;

  assign wr_en = i_psel && i_penable && i_pwrite;

  // Sleep wakes on any source, hibernate only on GPIO
  assign wake_cond = o_isolate_mem ? i_gpio_irq : (i_gpio_irq || i_ttc_irq || (|i_ext_irq));

  always_ff @(posedge i_hclk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      o_isolate_mem <= 1'b0;
      wake_cond_q   <= 1'b0;
      pending       <= 1'b0;
    end else begin
      wake_cond_q <= wake_cond;
      if (wr_en && i_paddr == apb_sub_pkg::PWR_CTRL) o_isolate_mem <= i_pwdata[0];
      if (wake_cond && !wake_cond_q) pending <= 1'b1; // Rising edge sets
      else if (wr_en && i_paddr == apb_sub_pkg::PWR_STAT && i_pwdata[0]) pending <= 1'b0;
    end
  end

  assign o_prdata  = (i_paddr == apb_sub_pkg::PWR_CTRL) ? {31'b0, o_isolate_mem} :
                     (i_paddr == apb_sub_pkg::PWR_STAT) ? {31'b0, pending} : 32'b0;
  assign o_pcm_irq = pending;

endmodule

`default_nettype wire

/* source/interval_timer.sv */
// Interval timer with control, interval, count and status registers and expiry interrupt
`timescale 1ns/1ps
`default_nettype none

module interval_timer (
  input  wire         i_hclk,
  input  wire         i_rst_n,
  input  wire         i_psel,
  input  wire         i_penable,
  input  wire         i_pwrite,
  input  wire  [4:0]  i_paddr,
  input  wire  [31:0] i_pwdata,
  output logic [31:0] o_prdata,
  output logic        o_ttc_irq
);

  logic [1:0]  ctrl;     // [0] run, [1] irq enable
  logic [15:0] interval;
  logic [15:0] count;
  logic        expired;  // Sticky wrap flag
  logic        wr_en;

  assign wr_en = i_psel && i_penable && i_pwrite;

  always_ff @(posedge i_hclk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      ctrl     <= '0;
      interval <= '0;
      count    <= '0;
      expired  <= 1'b0;
    end else begin
      // Counter, restarted by any control write
      if (wr_en && i_paddr == apb_sub_pkg::TTC_CTRL) begin
        ctrl  <= i_pwdata[1:0];
        count <= '0;
      end else if (ctrl[0]) begin
        count <= (count == interval) ? '0 : count + 16'd1; // Period is interval+1
      end
      if (wr_en && i_paddr == apb_sub_pkg::TTC_INTERVAL) interval <= i_pwdata[15:0];
      // Expiry flag, wrap wins over W1C
      if (ctrl[0] && count == interval && !(wr_en && i_paddr == apb_sub_pkg::TTC_CTRL)) begin
        expired <= 1'b1;
      end else if (wr_en && i_paddr == apb_sub_pkg::TTC_STAT && i_pwdata[0]) begin
        expired <= 1'b0;
      end
    end
  end

  always_comb begin
    case (i_paddr)
      apb_sub_pkg::TTC_CTRL:     o_prdata = {30'b0, ctrl};
      apb_sub_pkg::TTC_INTERVAL: o_prdata = {16'b0, interval};
      apb_sub_pkg::TTC_COUNT:    o_prdata = {16'b0, count};
      apb_sub_pkg::TTC_STAT:     o_prdata = {31'b0, expired};
      default:                   o_prdata = '0;
    endcase
  end

  assign o_ttc_irq = expired && ctrl[1];

endmodule

`default_nettype wire

/* source/gpio_block.sv */
// GPIO registers, two-flop input synchroniser and masked pin-change interrupt
`timescale 1ns/1ps
`default_nettype none

module gpio_block #(
  parameter int GPIO_WIDTH = 16
) (
  input  wire                   i_hclk,
  input  wire                   i_rst_n,
  input  wire                   i_psel,
  input  wire                   i_penable,
  input  wire                   i_pwrite,
  input  wire  [4:0]            i_paddr,
  input  wire  [31:0]           i_pwdata,
  input  wire  [GPIO_WIDTH-1:0] i_gpio_pin_in,
  output logic [31:0]           o_prdata,
  output logic [GPIO_WIDTH-1:0] o_gpio_pin_out,
  output logic [GPIO_WIDTH-1:0] o_n_gpio_pin_oe,
  output logic                  o_gpio_irq
);

  logic [GPIO_WIDTH-1:0] dout;
  logic [GPIO_WIDTH-1:0] oe;
  logic [GPIO_WIDTH-1:0] mask;
  logic [GPIO_WIDTH-1:0] stat;      // Sticky change bits
  logic [GPIO_WIDTH-1:0] sync_1;    // First synchroniser stage
  logic [GPIO_WIDTH-1:0] din;       // Second stage, seen as GPIO_DIN
  logic [GPIO_WIDTH-1:0] din_prev;  // Last cycle's din
  logic [GPIO_WIDTH-1:0] change;
  logic [GPIO_WIDTH-1:0] stat_clr;
  logic                  wr_en;

  assign wr_en    = i_psel && i_penable && i_pwrite; // Access cycle write
  assign change   = din ^ din_prev;
  assign stat_clr = (wr_en && i_paddr == apb_sub_pkg::GPIO_STAT) ?
                    i_pwdata[GPIO_WIDTH-1:0] : '0;

  always_ff @(posedge i_hclk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      dout     <= '0;
      oe       <= '0;
      mask     <= '0;
      stat     <= '0;
      sync_1   <= '0;
      din      <= '0;
      din_prev <= '0;
    end else begin
      sync_1   <= i_gpio_pin_in;
      din      <= sync_1;
      din_prev <= din;
      stat     <= (stat & ~stat_clr) | change; // New change beats the clear
      if (wr_en) begin
        case (i_paddr)
          apb_sub_pkg::GPIO_DOUT: dout <= i_pwdata[GPIO_WIDTH-1:0];
          apb_sub_pkg::GPIO_OE:   oe   <= i_pwdata[GPIO_WIDTH-1:0];
          apb_sub_pkg::GPIO_MASK: mask <= i_pwdata[GPIO_WIDTH-1:0];
          default: ;                            // DIN read-only, STAT above
        endcase
      end
    end
  end

  // Register read mux
  always_comb begin
    case (i_paddr)
      apb_sub_pkg::GPIO_DOUT: o_prdata = 32'(dout);
      apb_sub_pkg::GPIO_OE:   o_prdata = 32'(oe);
      apb_sub_pkg::GPIO_DIN:  o_prdata = 32'(din);
      apb_sub_pkg::GPIO_MASK: o_prdata = 32'(mask);
      apb_sub_pkg::GPIO_STAT: o_prdata = 32'(stat);
      default:                o_prdata = '0;
    endcase
  end

  assign o_gpio_pin_out  = dout;
  assign o_n_gpio_pin_oe = ~oe;           // Pad enable is active low
  assign o_gpio_irq      = |(stat & mask); // Mask bit set lets it through

endmodule

`default_nettype wire

/* source/ahb_apb_bridge.sv */
// AHB-lite slave to APB bridge with setup/access sequencer, slot decoder and read mux
`timescale 1ns/1ps
`default_nettype none

module ahb_apb_bridge (
  input  wire         i_hclk,
  input  wire         i_rst_n,
  // AHB-lite slave side
  input  wire         i_hsel,
  input  wire  [31:0] i_haddr,
  input  wire  [1:0]  i_htrans,
  input  wire         i_hwrite,
  input  wire  [31:0] i_hwdata,
  input  wire         i_hready_in,
  output logic [31:0] o_hrdata,
  output logic        o_hready,
  output logic [1:0]  o_hresp,
  // APB master side
  input  wire  [31:0] i_prdata_gpio,
  input  wire  [31:0] i_prdata_ttc,
  input  wire  [31:0] i_prdata_pwr,
  output logic [4:0]  o_paddr,
  output logic        o_pwrite,
  output logic [31:0] o_pwdata,
  output logic        o_penable,
  output logic        o_psel_gpio,
  output logic        o_psel_ttc,
  output logic        o_psel_pwr
);

  localparam int SLOT_BITS = 24 - apb_sub_pkg::SLOT_SPAN_BITS; // Width of haddr[23:16]

  apb_sub_pkg::bridge_state_e state;
  apb_sub_pkg::slot_e         slot_q;   // Decoded slot of the transfer in flight
  logic [4:0]                 addr_q;   // Register offset
  logic                       write_q;
  logic [31:0]                wdata_q;
  logic [31:0]                prdata_mux;
  logic [SLOT_BITS-1:0]       slot_idx;
  logic                       in_window;
  logic                       mapped;
  logic                       xfer_req;
  logic                       apb_active;

  // ----------------------------------------
  // Address phase decode
  // ----------------------------------------
  assign xfer_req = i_hsel && i_hready_in &&
                    (i_htrans == apb_sub_pkg::HTRANS_NONSEQ ||
                     i_htrans == apb_sub_pkg::HTRANS_SEQ);
  assign in_window = (i_haddr[31:24] == apb_sub_pkg::APB_BASE[31:24]);
  // Slot index relative to base, wraps below base to a large value
  assign slot_idx = i_haddr[23:apb_sub_pkg::SLOT_SPAN_BITS] -
                    apb_sub_pkg::APB_BASE[23:apb_sub_pkg::SLOT_SPAN_BITS];
  assign mapped = in_window && (slot_idx < SLOT_BITS'(3)); // Only slots 0..2 exist

  // ----------------------------------------
  // Sequencer
  // ----------------------------------------
  always_ff @(posedge i_hclk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      state    <= apb_sub_pkg::ST_IDLE;
      o_hready <= 1'b1;
      o_hresp  <= apb_sub_pkg::HRESP_OKAY;
      slot_q   <= apb_sub_pkg::SLOT_GPIO;
      addr_q   <= '0;
      write_q  <= 1'b0;
    end else begin
      case (state)
        apb_sub_pkg::ST_IDLE: begin
          o_hresp <= apb_sub_pkg::HRESP_OKAY; // Ends the second ERROR cycle
          if (xfer_req) begin
            addr_q   <= i_haddr[4:0];
            write_q  <= i_hwrite;
            slot_q   <= apb_sub_pkg::slot_e'(slot_idx[1:0]);
            o_hready <= 1'b0;                 // Stall the data phase
            if (mapped) begin
              state <= apb_sub_pkg::ST_SETUP;
            end else begin
              state   <= apb_sub_pkg::ST_ERROR; // First ERROR cycle, hready low
              o_hresp <= apb_sub_pkg::HRESP_ERROR;
            end
          end
        end
        apb_sub_pkg::ST_SETUP:  state <= apb_sub_pkg::ST_ACCESS;
        apb_sub_pkg::ST_ACCESS: begin
          state    <= apb_sub_pkg::ST_IDLE;
          o_hready <= 1'b1;                   // Read data valid with this
        end
        apb_sub_pkg::ST_ERROR: begin
          state    <= apb_sub_pkg::ST_IDLE;
          o_hready <= 1'b1;                   // hresp held at ERROR
        end
        default: state <= apb_sub_pkg::ST_IDLE;
      endcase
    end
  end

  // Write data arrives in the AHB data phase
  always_ff @(posedge i_hclk) begin
    if (state == apb_sub_pkg::ST_SETUP) wdata_q <= i_hwdata;
    if (state == apb_sub_pkg::ST_ACCESS && !write_q) o_hrdata <= prdata_mux;
  end

  // Read data select by slot
  always_comb begin
    case (slot_q)
      apb_sub_pkg::SLOT_GPIO: prdata_mux = i_prdata_gpio;
      apb_sub_pkg::SLOT_TTC:  prdata_mux = i_prdata_ttc;
      apb_sub_pkg::SLOT_PWR:  prdata_mux = i_prdata_pwr;
      default:                prdata_mux = '0;
    endcase
  end

  // ----------------------------------------
  // APB outputs
  // ----------------------------------------
  assign apb_active  = (state == apb_sub_pkg::ST_SETUP) || (state == apb_sub_pkg::ST_ACCESS);
  assign o_paddr     = addr_q;
  assign o_pwrite    = write_q;
  assign o_pwdata    = (state == apb_sub_pkg::ST_SETUP) ? i_hwdata : wdata_q; // Pass in setup
  assign o_penable   = (state == apb_sub_pkg::ST_ACCESS);
  assign o_psel_gpio = apb_active && (slot_q == apb_sub_pkg::SLOT_GPIO);
  assign o_psel_ttc  = apb_active && (slot_q == apb_sub_pkg::SLOT_TTC);
  assign o_psel_pwr  = apb_active && (slot_q == apb_sub_pkg::SLOT_PWR);

endmodule

`default_nettype wire

/* source/apb_sub_pkg.sv */
// Subsystem address map, slot and register offset enums, bridge state enum, AHB codes
`default_nettype none

package apb_sub_pkg;

  // ----------------------------------------
  // Address map
  // ----------------------------------------
  localparam logic [31:0] APB_BASE = 32'h0080_0000; // Slot 0 starts here
  localparam int SLOT_SPAN_BITS = 16;                // 64 KB per slot

  // Peripheral slots, slot 3 and up unmapped
  typedef enum logic [1:0] {
    SLOT_GPIO = 2'd0,
    SLOT_TTC  = 2'd1,
    SLOT_PWR  = 2'd2
  } slot_e;

  // ----------------------------------------
  // Register word offsets
  // ----------------------------------------
  typedef enum logic [4:0] {
    GPIO_DOUT = 5'h00, // Output data
    GPIO_OE   = 5'h04, // Output enable, active high
    GPIO_DIN  = 5'h08, // Synchronised pins, RO
    GPIO_MASK = 5'h0C, // Change irq mask
    GPIO_STAT = 5'h10  // Change status, W1C
  } gpio_reg_e;

  typedef enum logic [4:0] {
    TTC_CTRL     = 5'h00, // [0] enable, [1] irq enable
    TTC_INTERVAL = 5'h04,
    TTC_COUNT    = 5'h08, // RO
    TTC_STAT     = 5'h0C  // [0] expiry, W1C
  } ttc_reg_e;

  typedef enum logic [4:0] {
    PWR_CTRL = 5'h00, // [0] isolate_mem
    PWR_STAT = 5'h04  // [0] wake pending, W1C
  } pwr_reg_e;

  // Bridge sequencer
  typedef enum logic [1:0] {ST_IDLE, ST_SETUP, ST_ACCESS, ST_ERROR} bridge_state_e;

  // AHB-lite transfer and response codes
  localparam logic [1:0] HTRANS_NONSEQ = 2'b10;
  localparam logic [1:0] HTRANS_SEQ    = 2'b11;
  localparam logic [1:0] HRESP_OKAY    = 2'b00;
  localparam logic [1:0] HRESP_ERROR   = 2'b01;

endpackage

`default_nettype wire
